//--- src/dmmu_pkg.sv
// DMMU shared definitions

package dmmu_pkg;

  //////////////////////////////////////////////////
  // Page and SPR constants
  //////////////////////////////////////////////////

  // 8 KB pages
  localparam int unsigned PAGE_BITS = 13;

  // SPR group of the data MMU, taken from address bits 15:11
  localparam logic [4:0] SPR_GROUP_DMMU = 5'd1;

  // Control register, holds the page-table base in bits 31:10
  localparam logic [15:0] SPR_DMMUCR_ADDR = 16'h0800;

  //////////////////////////////////////////////////
  // TLB and page-table entries
  //////////////////////////////////////////////////

  // TLB match entry
  typedef struct packed {
    logic [18:0] vpn;
    logic [11:0] rsv;
    logic        v;
  } dtlbmr_t;

  // TLB translate entry
  typedef struct packed {
    logic [18:0] ppn;
    logic [2:0]  rsv;
    // Supervisor write and read, user write and read
    logic        swe;
    logic        sre;
    logic        uwe;
    logic        ure;
    logic        d;
    logic        a;
    logic        wom;
    logic        wbc;
    logic        ci;
    logic        cc;
  } dtlbtr_t;

  // Page-table entry, also the layout of the first-level pointer
  typedef struct packed {
    logic [18:0] ppn;
    logic [1:0]  rsv;
    logic        present;
    logic        l;
    logic        x;
    logic        w;
    logic        u;
    // Low six bits go straight into the translate entry
    logic        d;
    logic        a;
    logic        wom;
    logic        wbc;
    logic        ci;
    logic        cc;
  } pte_t;

  //////////////////////////////////////////////////
  // Bus groups
  //////////////////////////////////////////////////

  // SPR request from the core
  typedef struct packed {
    logic        stb;
    logic        we;
    logic [15:0] addr;
    logic [31:0] dat;
  } spr_req_t;

  // Wishbone classic master request, read only
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic [31:0] adr;
  } wb_m2s_t;

  // TLB write from the hardware reload
  typedef struct packed {
    logic    we;
    dtlbmr_t match;
    dtlbtr_t trans;
  } tlb_wr_t;

endpackage

//--- src/dtlb_ram.sv
// DTLB match and translate arrays

`timescale 1ns/1ps

module dtlb_ram #(
  parameter int unsigned SET_WIDTH = 6
) (
  input  logic                clk,
  input  logic [31:0]         virt_addr_i,
  input  dmmu_pkg::spr_req_t  spr_i,
  input  logic                match_sel_i,
  input  logic                trans_sel_i,
  input  dmmu_pkg::tlb_wr_t   reload_i,
  input  logic [31:0]         virt_addr_match_i,
  output dmmu_pkg::dtlbmr_t   match_o,
  output dmmu_pkg::dtlbtr_t   trans_o
);

  localparam int unsigned DEPTH = 2 ** SET_WIDTH;

  dmmu_pkg::dtlbmr_t    match_mem [DEPTH];
  dmmu_pkg::dtlbtr_t    trans_mem [DEPTH];

  logic [SET_WIDTH-1:0] lookup_set;
  logic [SET_WIDTH-1:0] reload_set;
  logic [SET_WIDTH-1:0] spr_set;
  logic [SET_WIDTH-1:0] match_addr;
  logic [SET_WIDTH-1:0] trans_addr;
  logic                 match_we;
  logic                 trans_we;
  dmmu_pkg::dtlbmr_t    match_din;
  dmmu_pkg::dtlbtr_t    trans_din;

  // Set index sources
  assign lookup_set = virt_addr_i[dmmu_pkg::PAGE_BITS +: SET_WIDTH];
  assign reload_set = virt_addr_match_i[dmmu_pkg::PAGE_BITS +: SET_WIDTH];
  assign spr_set    = spr_i.addr[SET_WIDTH-1:0];

  // Reload first, then SPR, otherwise the next lookup
  assign match_addr = reload_i.we ? reload_set :
                      match_sel_i ? spr_set : lookup_set;
  assign trans_addr = reload_i.we ? reload_set :
                      trans_sel_i ? spr_set : lookup_set;

  // Both arrays are written together by a reload
  assign match_we = reload_i.we | (match_sel_i & spr_i.we);
  assign trans_we = reload_i.we | (trans_sel_i & spr_i.we);

  assign match_din = reload_i.we ? reload_i.match : dmmu_pkg::dtlbmr_t'(spr_i.dat);
  assign trans_din = reload_i.we ? reload_i.trans : dmmu_pkg::dtlbtr_t'(spr_i.dat);

  //////////////////////////////////////////////////
  // Single port arrays, write first
  //////////////////////////////////////////////////

  // A written word shows up on the read port in the next cycle
  always_ff @(posedge clk) begin
    if (match_we) begin
      match_mem[match_addr] <= match_din;
      match_o               <= match_din;
    end else begin
      match_o <= match_mem[match_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (trans_we) begin
      trans_mem[trans_addr] <= trans_din;
      trans_o               <= trans_din;
    end else begin
      trans_o <= trans_mem[trans_addr];
    end
  end

endmodule

//--- src/dmmu_lookup.sv
// DTLB hit check and translation

`timescale 1ns/1ps

module dmmu_lookup (
  input  dmmu_pkg::dtlbmr_t match_i,
  input  dmmu_pkg::dtlbtr_t trans_i,
  input  logic [31:0]       virt_addr_match_i,
  input  logic              op_load_i,
  input  logic              op_store_i,
  input  logic              supervisor_mode_i,
  input  logic              reload_busy_i,
  input  logic              reload_pagefault_i,
  output logic [31:0]       phys_addr_o,
  output logic              cache_inhibit_o,
  output logic              tlb_miss_o,
  output logic              pagefault_o
);

  localparam int unsigned VPN_BITS = 32 - dmmu_pkg::PAGE_BITS;

  logic [VPN_BITS-1:0]            vpn;
  logic [dmmu_pkg::PAGE_BITS-1:0] offset;
  logic                           hit;
  logic                           read_ok;
  logic                           write_ok;
  logic                           load_fault;
  logic                           store_fault;

  assign vpn    = virt_addr_match_i[31:dmmu_pkg::PAGE_BITS];
  assign offset = virt_addr_match_i[dmmu_pkg::PAGE_BITS-1:0];

  //////////////////////////////////////////////////
  // Tag compare
  //////////////////////////////////////////////////

  // Arrays were read with the same address one cycle earlier
  assign hit = match_i.v & (match_i.vpn == vpn);

  // A pending reload fault is reported in place of the miss
  assign tlb_miss_o = ~hit & ~reload_pagefault_i;

  // Page number from the entry, offset from the address
  // On a miss only the offset is passed on
  assign phys_addr_o = hit ? {trans_i.ppn, offset} : {{VPN_BITS{1'b0}}, offset};

  assign cache_inhibit_o = hit & trans_i.ci;

  //////////////////////////////////////////////////
  // Access rights
  //////////////////////////////////////////////////

  // Supervisor or user pair by mode
  assign read_ok  = supervisor_mode_i ? trans_i.sre : trans_i.ure;
  assign write_ok = supervisor_mode_i ? trans_i.swe : trans_i.uwe;

  assign load_fault  = op_load_i & ~read_ok;
  assign store_fault = op_store_i & ~write_ok;

  // Rights only count for a hit
  // no fault while the walk may still replace the entry
  assign pagefault_o = hit & (load_fault | store_fault) & ~reload_busy_i;

endmodule

//--- src/dmmu_spr.sv
// DMMU SPR access and control register

`timescale 1ns/1ps

module dmmu_spr (
  input  logic               clk,
  input  logic               rst,
  input  dmmu_pkg::spr_req_t spr_i,
  input  dmmu_pkg::dtlbmr_t  match_i,
  input  dmmu_pkg::dtlbtr_t  trans_i,
  output logic               match_sel_o,
  output logic               trans_sel_o,
  output logic [21:0]        dmmucr_base_o,
  output logic [31:0]        spr_dat_o,
  output logic               spr_ack_o
);

  logic        group_sel;
  logic        tlb_sel;
  logic        dmmucr_sel;
  logic        match_sel_q;
  logic        trans_sel_q;
  logic        dmmucr_sel_q;
  logic        ack_q;
  logic [31:0] dmmucr_q;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  // Group 1 lives in address bits 15:11
  assign group_sel = spr_i.stb & (spr_i.addr[15:11] == dmmu_pkg::SPR_GROUP_DMMU);

  // TLB space starts where bits 10:9 are nonzero
  assign tlb_sel = group_sel & (|spr_i.addr[10:9]);

  // Bit 7 splits match words from translate words
  assign match_sel_o = tlb_sel & ~spr_i.addr[7];
  assign trans_sel_o = tlb_sel & spr_i.addr[7];

  assign dmmucr_sel = spr_i.stb & (spr_i.addr == dmmu_pkg::SPR_DMMUCR_ADDR);

  //////////////////////////////////////////////////
  // Control register and acknowledge
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dmmucr_q <= '0;
    end else if (dmmucr_sel & spr_i.we) begin
      dmmucr_q <= spr_i.dat;
    end
  end

  // Page-table base for the reload walk
  assign dmmucr_base_o = dmmucr_q[31:10];

  // Selects follow the array read by one cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      match_sel_q  <= 1'b0;
      trans_sel_q  <= 1'b0;
      dmmucr_sel_q <= 1'b0;
      ack_q        <= 1'b0;
    end else begin
      match_sel_q  <= match_sel_o;
      trans_sel_q  <= trans_sel_o;
      dmmucr_sel_q <= dmmucr_sel;
      ack_q        <= group_sel;
    end
  end

  // High from the second strobe cycle, low as soon as the strobe drops
  assign spr_ack_o = ack_q & group_sel;

  // Readback, valid in the acknowledge cycle
  always_comb begin
    if (match_sel_q) begin
      spr_dat_o = match_i;
    end else if (trans_sel_q) begin
      spr_dat_o = trans_i;
    end else if (dmmucr_sel_q) begin
      spr_dat_o = dmmucr_q;
    end else begin
      spr_dat_o = '0;
    end
  end

endmodule

//--- src/dmmu_reload_ctrl.sv
// DTLB hardware reload walker

`timescale 1ns/1ps

module dmmu_reload_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              enable_i,
  input  logic              op_load_i,
  input  logic              op_store_i,
  input  logic              tlb_miss_i,
  input  logic [31:0]       virt_addr_match_i,
  input  logic [21:0]       dmmucr_base_i,
  input  logic              reload_pagefault_clear_i,
  input  logic [31:0]       wb_dat_i,
  input  logic              wb_ack_i,
  output dmmu_pkg::wb_m2s_t wb_o,
  output dmmu_pkg::tlb_wr_t reload_o,
  output logic              reload_busy_o,
  output logic              reload_pagefault_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_GET_PTR,
    ST_GET_PTE,
    ST_SETTLE
  } state_e;

  state_e            state_q;
  logic              wb_req_q;
  logic [31:0]       wb_adr_q;
  logic              pf_q;
  logic              we_q;
  dmmu_pkg::dtlbmr_t match_q;
  dmmu_pkg::dtlbtr_t trans_q;
  dmmu_pkg::pte_t    pte;
  logic              base_valid;
  logic              do_reload;
  logic              ptr_ack;
  logic              pte_ack;

  // Read data seen as a page-table entry
  assign pte = dmmu_pkg::pte_t'(wb_dat_i);

  // Reload is off while DMMUCR holds zero
  assign base_valid = |dmmucr_base_i;
  assign do_reload  = enable_i & tlb_miss_i & base_valid & (op_load_i | op_store_i);

  // Busy already in the missing cycle
  assign reload_busy_o = (enable_i & (state_q != ST_IDLE)) | do_reload;

  assign reload_pagefault_o = pf_q & ~reload_pagefault_clear_i;

  assign ptr_ack = (state_q == ST_GET_PTR) & wb_ack_i;
  assign pte_ack = (state_q == ST_GET_PTE) & wb_req_q & wb_ack_i;

  // Classic cycle, cyc and stb always together
  assign wb_o.cyc = wb_req_q;
  assign wb_o.stb = wb_req_q;
  assign wb_o.adr = wb_adr_q;

  assign reload_o.we    = we_q;
  assign reload_o.match = match_q;
  assign reload_o.trans = trans_q;

  //////////////////////////////////////////////////
  // Walk FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q  <= ST_IDLE;
      wb_req_q <= 1'b0;
      pf_q     <= 1'b0;
      we_q     <= 1'b0;
    end else begin
      we_q <= 1'b0;
      if (reload_pagefault_clear_i) begin
        pf_q <= 1'b0;
      end
      case (state_q)
        ST_IDLE: begin
          if (do_reload) begin
            wb_req_q <= 1'b1;
            state_q  <= ST_GET_PTR;
          end
        end
        // First level, pointer to the PTE table
        ST_GET_PTR: begin
          if (ptr_ack) begin
            wb_req_q <= 1'b0;
            if (pte.ppn == '0) begin
              pf_q    <= 1'b1;
              state_q <= ST_IDLE;
            end else begin
              state_q <= ST_GET_PTE;
            end
          end
        end
        // One idle bus cycle, then the PTE read
        ST_GET_PTE: begin
          if (!wb_req_q) begin
            wb_req_q <= 1'b1;
          end else if (pte_ack) begin
            wb_req_q <= 1'b0;
            if (!pte.present) begin
              pf_q    <= 1'b1;
              state_q <= ST_IDLE;
            end else begin
              we_q    <= 1'b1;
              state_q <= ST_SETTLE;
            end
          end
        end
        // Entry is written here and read back in the next cycle
        ST_SETTLE: begin
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
      // Abort on disable or cleared DMMUCR
      if (!enable_i || !base_valid) begin
        state_q  <= ST_IDLE;
        wb_req_q <= 1'b0;
        we_q     <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Bus address and new entry
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // Pointer index from VA 31:24, PTE index from VA 23:13
    if ((state_q == ST_IDLE) && do_reload) begin
      wb_adr_q <= {dmmucr_base_i, virt_addr_match_i[31:24], 2'b00};
    end else if (ptr_ack) begin
      wb_adr_q <= {pte.ppn, virt_addr_match_i[23:13], 2'b00};
    end
    if (pte_ack) begin
      trans_q.ppn <= pte.ppn;
      trans_q.rsv <= '0;
      // X is not used by the data side
      trans_q.swe <= pte.w;
      trans_q.sre <= 1'b1;
      trans_q.uwe <= pte.w & pte.u;
      trans_q.ure <= pte.u;
      trans_q.d   <= pte.d;
      trans_q.a   <= pte.a;
      trans_q.wom <= pte.wom;
      trans_q.wbc <= pte.wbc;
      trans_q.ci  <= pte.ci;
      trans_q.cc  <= pte.cc;
      match_q.vpn <= virt_addr_match_i[31:dmmu_pkg::PAGE_BITS];
      match_q.rsv <= '0;
      match_q.v   <= 1'b1;
    end
  end

endmodule

//--- src/dmmu_top.sv
// Data MMU top level

`timescale 1ns/1ps

module dmmu_top #(
  parameter int unsigned SET_WIDTH = 6
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               enable_i,
  input  logic [31:0]        virt_addr_i,
  input  logic [31:0]        virt_addr_match_i,
  input  logic               op_load_i,
  input  logic               op_store_i,
  input  logic               supervisor_mode_i,
  output logic [31:0]        phys_addr_o,
  output logic               cache_inhibit_o,
  output logic               tlb_miss_o,
  output logic               pagefault_o,
  output logic               reload_busy_o,
  output logic               reload_pagefault_o,
  input  logic               reload_pagefault_clear_i,
  input  dmmu_pkg::spr_req_t spr_i,
  output logic [31:0]        spr_dat_o,
  output logic               spr_ack_o,
  output dmmu_pkg::wb_m2s_t  wb_o,
  input  logic [31:0]        wb_dat_i,
  input  logic               wb_ack_i
);

  dmmu_pkg::dtlbmr_t match_word;
  dmmu_pkg::dtlbtr_t trans_word;
  dmmu_pkg::tlb_wr_t reload_wr;
  logic              match_sel;
  logic              trans_sel;
  logic [21:0]       dmmucr_base;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  // Page-table walk on a miss
  dmmu_reload_ctrl u_reload_ctrl (
    .clk                      (clk),
    .rst                      (rst),
    .enable_i                 (enable_i),
    .op_load_i                (op_load_i),
    .op_store_i               (op_store_i),
    .tlb_miss_i               (tlb_miss_o),
    .virt_addr_match_i        (virt_addr_match_i),
    .dmmucr_base_i            (dmmucr_base),
    .reload_pagefault_clear_i (reload_pagefault_clear_i),
    .wb_dat_i                 (wb_dat_i),
    .wb_ack_i                 (wb_ack_i),
    .wb_o                     (wb_o),
    .reload_o                 (reload_wr),
    .reload_busy_o            (reload_busy_o),
    .reload_pagefault_o       (reload_pagefault_o)
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  dtlb_ram #(
    .SET_WIDTH (SET_WIDTH)
  ) u_dtlb_ram (
    .clk               (clk),
    .virt_addr_i       (virt_addr_i),
    .spr_i             (spr_i),
    .match_sel_i       (match_sel),
    .trans_sel_i       (trans_sel),
    .reload_i          (reload_wr),
    .virt_addr_match_i (virt_addr_match_i),
    .match_o           (match_word),
    .trans_o           (trans_word)
  );

  dmmu_lookup u_lookup (
    .match_i            (match_word),
    .trans_i            (trans_word),
    .virt_addr_match_i  (virt_addr_match_i),
    .op_load_i          (op_load_i),
    .op_store_i         (op_store_i),
    .supervisor_mode_i  (supervisor_mode_i),
    .reload_busy_i      (reload_busy_o),
    .reload_pagefault_i (reload_pagefault_o),
    .phys_addr_o        (phys_addr_o),
    .cache_inhibit_o    (cache_inhibit_o),
    .tlb_miss_o         (tlb_miss_o),
    .pagefault_o        (pagefault_o)
  );

  // SPR side, also owns DMMUCR
  dmmu_spr u_spr (
    .clk           (clk),
    .rst           (rst),
    .spr_i         (spr_i),
    .match_i       (match_word),
    .trans_i       (trans_word),
    .match_sel_o   (match_sel),
    .trans_sel_o   (trans_sel),
    .dmmucr_base_o (dmmucr_base),
    .spr_dat_o     (spr_dat_o),
    .spr_ack_o     (spr_ack_o)
  );

endmodule

//--- bench/pt_mem_wb.sv
// Page-table memory model

`timescale 1ns/1ps

module pt_mem_wb (
  input  logic              clk,
  input  logic              rst,
  input  dmmu_pkg::wb_m2s_t wb_i,
  output logic [31:0]       wb_dat_o,
  output logic              wb_ack_o
);

  // Word array, indexed by address bits 13:2
  logic [31:0] mem [4096];
  logic        active_q;
  logic [1:0]  delay_q;
  logic [31:0] rng_q;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  initial begin
    for (int i = 0; i < 4096; i++) begin
      mem[i] = '0;
    end
  end

  //////////////////////////////////////////////////
  // Classic read slave
  //////////////////////////////////////////////////

  // Each request waits 0 to 3 extra cycles, two LFSR bits
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
      active_q <= 1'b0;
      delay_q  <= '0;
      rng_q    <= 32'ha275;
    end else if (wb_ack_o) begin
      wb_ack_o <= 1'b0;
      active_q <= 1'b0;
    end else if (wb_i.cyc && wb_i.stb) begin
      if (!active_q) begin
        active_q <= 1'b1;
        delay_q  <= rng_q[1:0];
        rng_q    <= lfsr_step(lfsr_step(rng_q));
      end else if (delay_q == 2'd0) begin
        wb_ack_o <= 1'b1;
        wb_dat_o <= mem[wb_i.adr[13:2]];
      end else begin
        delay_q <= delay_q - 2'd1;
      end
    end
  end

endmodule

//--- bench/tb_dmmu.sv
// DMMU testbench

`timescale 1ns/1ps

module tb_dmmu;

  localparam int TIMEOUT = 200;
  // Page-table base of 1 puts the pointer table at byte 0x400
  localparam logic [31:0] CR_VAL = 32'h0000_0400;

  logic               clk;
  logic               rst;
  logic               enable_i;
  logic [31:0]        virt_addr_i;
  logic [31:0]        virt_addr_match_i;
  logic               op_load_i;
  logic               op_store_i;
  logic               supervisor_mode_i;
  logic [31:0]        phys_addr_o;
  logic               cache_inhibit_o;
  logic               tlb_miss_o;
  logic               pagefault_o;
  logic               reload_busy_o;
  logic               reload_pagefault_o;
  logic               reload_pagefault_clear_i;
  dmmu_pkg::spr_req_t spr_i;
  logic [31:0]        spr_dat_o;
  logic               spr_ack_o;
  dmmu_pkg::wb_m2s_t  wb_o;
  logic [31:0]        wb_dat;
  logic               wb_ack;

  int                 errors;
  int                 timeouts;
  int                 checks;
  logic [31:0]        rng_state;
  logic [31:0]        cr_shadow;
  logic [31:0]        wb_addrs [$];

  dmmu_top #(
    .SET_WIDTH (6)
  ) DUT (
    .clk (clk), .rst (rst), .enable_i (enable_i),
    .virt_addr_i (virt_addr_i), .virt_addr_match_i (virt_addr_match_i),
    .op_load_i (op_load_i), .op_store_i (op_store_i),
    .supervisor_mode_i (supervisor_mode_i), .phys_addr_o (phys_addr_o),
    .cache_inhibit_o (cache_inhibit_o), .tlb_miss_o (tlb_miss_o),
    .pagefault_o (pagefault_o), .reload_busy_o (reload_busy_o),
    .reload_pagefault_o (reload_pagefault_o),
    .reload_pagefault_clear_i (reload_pagefault_clear_i),
    .spr_i (spr_i), .spr_dat_o (spr_dat_o), .spr_ack_o (spr_ack_o),
    .wb_o (wb_o), .wb_dat_i (wb_dat), .wb_ack_i (wb_ack)
  );

  pt_mem_wb u_pt_mem (
    .clk (clk), .rst (rst), .wb_i (wb_o), .wb_dat_o (wb_dat), .wb_ack_o (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Bus protocol assertions
  //////////////////////////////////////////////////

  // Strobe and address held until ack
  assert property (@(posedge clk) disable iff (rst)
      (wb_o.stb && !wb_ack) |=> (wb_o.stb && $stable(wb_o.adr)))
    else begin
      errors++;
      $display("stb or address dropped before ack at %0t", $time);
    end

  // No walk while DMMUCR holds zero
  assert property (@(posedge clk) disable iff (rst) wb_o.cyc |-> (cr_shadow != 0))
    else begin
      errors++;
      $display("Wishbone cycle started with DMMUCR zero at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (rst) spr_ack_o |-> spr_i.stb)
    else begin
      errors++;
      $display("SPR ack without strobe at %0t", $time);
    end

  // Addresses of completed reads
  always @(posedge clk) begin
    if (!rst && wb_o.cyc && wb_ack) begin
      wb_addrs.push_back(wb_o.adr);
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], rng_state[0]};
      rng_state = lfsr_step(rng_state);
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      end
  endtask

  task automatic spr_access(input logic we, input logic [15:0] addr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #1;
    spr_i.stb  = 1'b1;
    spr_i.we   = we;
    spr_i.addr = addr;
    spr_i.dat  = wdat;
    @(negedge clk);
    while (!spr_ack_o && cycles < TIMEOUT) begin
      cycles++;
      @(negedge clk);
    end
    if (!spr_ack_o) begin
      timeouts++;
      $display("timeout waiting for SPR acknowledge at %0t", $time);
    end
    check_value("spr_ack_latency", cycles, 1);
    rdat = spr_dat_o;
    @(posedge clk);
    #1;
    spr_i.stb = 1'b0;
    spr_i.we  = 1'b0;
  endtask

  task automatic spr_write(input logic [15:0] addr, input logic [31:0] wdat);
    logic [31:0] unused;
    spr_access(1'b1, addr, wdat, unused);
    if (addr == dmmu_pkg::SPR_DMMUCR_ADDR) begin
      cr_shadow = wdat;
    end
  endtask

  // Match address and ops follow the lookup address by one cycle
  task automatic lookup(input logic [31:0] va, input logic ld, input logic st,
                        input logic sup);
    @(posedge clk);
    #1;
    op_load_i         = 1'b0;
    op_store_i        = 1'b0;
    virt_addr_i       = va;
    supervisor_mode_i = sup;
    @(posedge clk);
    #1;
    virt_addr_match_i = va;
    op_load_i         = ld;
    op_store_i        = st;
    @(negedge clk);
  endtask

  task automatic check_rights(input logic [31:0] va, input logic [3:0] rights);
    logic exp;
    for (int sup = 0; sup < 2; sup++) begin
      for (int st = 0; st < 2; st++) begin
        lookup(va, !st, st, sup);
        // rights is {swe, sre, uwe, ure}
        exp = sup ? (st ? !rights[3] : !rights[2]) : (st ? !rights[1] : !rights[0]);
        check_value("pagefault_o", pagefault_o, exp);
      end
    end
    lookup(va, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic wait_reload_done();
    int cycles;
    cycles = 0;
    while (!reload_busy_o && cycles < TIMEOUT) begin
      cycles++;
      @(negedge clk);
    end
    while (reload_busy_o && cycles < TIMEOUT) begin
      cycles++;
      @(negedge clk);
    end
    if (reload_busy_o || cycles >= TIMEOUT) begin
      timeouts++;
      $display("timeout waiting for the reload walk at %0t", $time);
    end
  endtask

  function automatic logic [15:0] match_spr(input logic [31:0] va);
    return 16'h0A00 | va[18:13];
  endfunction

  function automatic logic [15:0] trans_spr(input logic [31:0] va);
    return 16'h0A80 | va[18:13];
  endfunction

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] va;
    logic [31:0] va2;
    logic [31:0] rd;
    logic [31:0] ptr_adr;
    logic [31:0] pte_adr;
    logic [18:0] ppn;
    errors = 0;
    timeouts = 0;
    checks = 0;
    rng_state = 32'ha275;
    cr_shadow = '0;
    rst = 1'b1;
    enable_i = 1'b1;
    virt_addr_i = '0;
    virt_addr_match_i = '0;
    op_load_i = 1'b0;
    op_store_i = 1'b0;
    supervisor_mode_i = 1'b0;
    reload_pagefault_clear_i = 1'b0;
    spr_i = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    // SPR readback of entries and DMMUCR
    va = take_bits(32);
    ppn = take_bits(19);
    spr_write(match_spr(va), {va[31:13], 12'h0, 1'b1});
    spr_write(trans_spr(va), {ppn, 3'h0, 4'b1111, 4'h0, 2'b10});
    spr_access(1'b0, match_spr(va), '0, rd);
    check_value("spr_dat_o match", rd, {va[31:13], 12'h0, 1'b1});
    spr_access(1'b0, trans_spr(va), '0, rd);
    check_value("spr_dat_o trans", rd, {ppn, 3'h0, 4'b1111, 4'h0, 2'b10});
    spr_write(dmmu_pkg::SPR_DMMUCR_ADDR, CR_VAL);
    spr_access(1'b0, dmmu_pkg::SPR_DMMUCR_ADDR, '0, rd);
    check_value("spr_dat_o dmmucr", rd, CR_VAL);
    spr_write(dmmu_pkg::SPR_DMMUCR_ADDR, 32'h0);

    // Hit on the SPR-written entry
    lookup(va, 1'b1, 1'b0, 1'b1);
    check_value("phys_addr_o", phys_addr_o, {ppn, va[12:0]});
    check_value("cache_inhibit_o", cache_inhibit_o, 1'b1);
    check_value("tlb_miss_o", tlb_miss_o, 1'b0);

    // Each rights bit set alone and then cleared alone
    for (int i = 0; i < 4; i++) begin
      spr_write(trans_spr(va), {ppn, 3'h0, 4'b0001 << i, 6'h0});
      check_rights(va, 4'b0001 << i);
      spr_write(trans_spr(va), {ppn, 3'h0, ~(4'b0001 << i), 6'h0});
      check_rights(va, ~(4'b0001 << i));
    end

    // Miss with reload off
    spr_write(match_spr(va), 32'h0);
    lookup(va, 1'b1, 1'b0, 1'b0);
    repeat (5) begin
      check_value("tlb_miss_o", tlb_miss_o, 1'b1);
      check_value("reload_busy_o", reload_busy_o, 1'b0);
      @(negedge clk);
    end
    lookup(va, 1'b0, 1'b0, 1'b0);

    // Two-level walk to a PTE with W set and both U and CI clear
    ptr_adr = {22'd1, va[31:24], 2'b00};
    pte_adr = {19'd1, va[23:13], 2'b00};
    ppn = take_bits(19) | 19'h1;
    u_pt_mem.mem[ptr_adr[13:2]] = {19'd1, 2'b00, 1'b1, 10'h0};
    u_pt_mem.mem[pte_adr[13:2]] = {ppn, 2'b00, 1'b1, 2'b00, 2'b10, 6'b000001};
    spr_write(dmmu_pkg::SPR_DMMUCR_ADDR, CR_VAL);
    wb_addrs.delete();
    lookup(va, 1'b1, 1'b0, 1'b0);
    wait_reload_done();
    check_value("wb read count", wb_addrs.size(), 2);
    if (wb_addrs.size() == 2) begin
      check_value("wb_o.adr pointer", wb_addrs[0], ptr_adr);
      check_value("wb_o.adr pte", wb_addrs[1], pte_adr);
    end
    check_value("tlb_miss_o", tlb_miss_o, 1'b0);
    check_value("phys_addr_o", phys_addr_o, {ppn, va[12:0]});
    check_value("cache_inhibit_o", cache_inhibit_o, 1'b0);
    // swe = 1, sre = 1, uwe = 0, ure = 0
    check_rights(va, 4'b1100);

    // Zero pointer
    va2 = va ^ 32'h8000_0000;
    spr_write(match_spr(va2), 32'h0);
    lookup(va2, 1'b1, 1'b0, 1'b0);
    wait_reload_done();
    lookup(va2, 1'b0, 1'b0, 1'b0);
    repeat (4) begin
      check_value("reload_pagefault_o", reload_pagefault_o, 1'b1);
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    reload_pagefault_clear_i = 1'b1;
    @(posedge clk);
    #1;
    reload_pagefault_clear_i = 1'b0;
    lookup(va2, 1'b0, 1'b0, 1'b0);
    check_value("reload_pagefault_o", reload_pagefault_o, 1'b0);
    check_value("tlb_miss_o", tlb_miss_o, 1'b1);

    // Valid pointer to a PTE without present
    va2 = va ^ 32'h0000_2000;
    spr_write(match_spr(va2), 32'h0);
    lookup(va2, 1'b0, 1'b1, 1'b0);
    wait_reload_done();
    lookup(va2, 1'b0, 1'b0, 1'b0);
    check_value("reload_pagefault_o", reload_pagefault_o, 1'b1);
    @(posedge clk);
    #1;
    reload_pagefault_clear_i = 1'b1;
    @(posedge clk);
    #1;
    reload_pagefault_clear_i = 1'b0;
    lookup(va2, 1'b0, 1'b0, 1'b0);
    check_value("tlb_miss_o", tlb_miss_o, 1'b1);

    $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Overall time limit
  initial begin
    #500us;
    $display("simulation time limit reached");
    $display("test failed");
    $finish;
  end

endmodule

//--- project.f
src/dmmu_pkg.sv
src/dtlb_ram.sv
src/dmmu_lookup.sv
src/dmmu_spr.sv
src/dmmu_reload_ctrl.sv
src/dmmu_top.sv
bench/pt_mem_wb.sv
bench/tb_dmmu.sv

//--- Bender.yml
package:
  name: dmmu

sources:
  - src/dmmu_pkg.sv
  - src/dtlb_ram.sv
  - src/dmmu_lookup.sv
  - src/dmmu_spr.sv
  - src/dmmu_reload_ctrl.sv
  - src/dmmu_top.sv
  - target: test
    files:
      - bench/pt_mem_wb.sv
      - bench/tb_dmmu.sv
